//--- build.f
+incdir+include
source/l1cache_pkg.sv
source/cache_array.sv
source/nmru.sv
source/l1cache_datapath.sv
source/l1cache_control.sv
source/l1cache.sv
verification/ddr_model.sv
verification/tb_l1cache.sv

//--- Bender.yml
package:
  name: l1cache

export_include_dirs:
  - include

sources:
  - target: rtl
    include_dirs:
      - include
    files:
      - source/l1cache_pkg.sv
      - source/cache_array.sv
      - source/nmru.sv
      - source/l1cache_datapath.sv
      - source/l1cache_control.sv
      - source/l1cache.sv
  - target: test
    files:
      - verification/ddr_model.sv
      - verification/tb_l1cache.sv

//--- verification/tb_l1cache.sv
`default_nettype none

module tb_l1cache
  import l1cache_pkg::*;
();

  localparam int    reset_cycles = 4;
  localparam int    idle_cycles  = 8;
  localparam int    resp_limit   = 40;
  localparam int    num_accesses = 42;
  localparam int    cycle_limit  = num_accesses * resp_limit + reset_cycles + idle_cycles;
  localparam int    shadow_words = 1024; // 4 kB window used by every test.
  localparam word_t seed         = 32'h19f33968;
  localparam int    any_kind     = 0;
  localparam int    hit_kind     = 1;
  localparam int    miss_kind    = 2;

  logic  clk;
  logic  rst_n;
  logic  core_req;
  logic  core_we;
  word_t core_addr;
  word_t core_wdata;
  logic  core_resp;
  word_t core_rdata;
  logic  ddr_req;
  logic  ddr_we;
  word_t ddr_addr;
  line_t ddr_wdata;
  logic  ddr_resp;
  line_t ddr_rdata;
  word_t fill_key;
  word_t write_count;
  word_t last_waddr;
  line_t last_wdata;

  word_t rng;
  word_t shadow [shadow_words];
  int    errors;
  int    cycles = 0;

  l1cache i_l1cache (
    .clk        (clk),
    .rst_n      (rst_n),
    .core_req   (core_req),
    .core_we    (core_we),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_resp  (core_resp),
    .core_rdata (core_rdata),
    .ddr_req    (ddr_req),
    .ddr_we     (ddr_we),
    .ddr_addr   (ddr_addr),
    .ddr_wdata  (ddr_wdata),
    .ddr_resp   (ddr_resp),
    .ddr_rdata  (ddr_rdata)
  );

  ddr_model i_ddr_model (
    .clk         (clk),
    .rst_n       (rst_n),
    .fill_key    (fill_key),
    .ddr_req     (ddr_req),
    .ddr_we      (ddr_we),
    .ddr_addr    (ddr_addr),
    .ddr_wdata   (ddr_wdata),
    .ddr_resp    (ddr_resp),
    .ddr_rdata   (ddr_rdata),
    .write_count (write_count),
    .last_waddr  (last_waddr),
    .last_wdata  (last_wdata)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic word_t lcg_next(word_t state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t next_random();
    rng = lcg_next(rng);
    return rng;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // starts and ends one unit after a rising edge.
  task automatic access(input logic we, input word_t addr, input word_t wdata,
                        output word_t rdata, output int lat, output int reqs);
    core_req   = 1'b1;
    core_we    = we;
    core_addr  = addr;
    core_wdata = wdata;
    @(posedge clk);
    #1;
    core_req = 1'b0;
    lat      = 1;
    reqs     = 0;
    rdata    = '0;
    while (!core_resp && lat < resp_limit) begin
      if (ddr_req) reqs++;
      @(posedge clk);
      #1;
      lat++;
    end
    if (ddr_req) reqs++; // the answering cycle counts too.
    if (core_resp) begin
      rdata = core_rdata;
    end else begin
      errors++;
      $display("no core_resp within %0d cycles for address %h", resp_limit, addr);
    end
    @(posedge clk); // control is back in idle after this edge.
    #1;
  endtask

  task automatic kind_checks(input int kind, input int lat, input int reqs);
    if (kind == hit_kind) begin
      check_flag("core_resp one cycle after core_req", lat == 1, 1'b1);
      check_flag("ddr_req during hit", reqs != 0, 1'b0);
    end else if (kind == miss_kind) begin
      check_flag("ddr_req during miss", reqs != 0, 1'b1);
    end
  endtask

  task automatic read_and_check(input word_t addr, input int kind);
    word_t rdata;
    int    lat;
    int    reqs;
    access(1'b0, addr, '0, rdata, lat, reqs);
    check_word("core_rdata", rdata, shadow[addr[11:2]]);
    kind_checks(kind, lat, reqs);
  endtask

  task automatic write_and_check(input word_t addr, input word_t data, input int kind);
    word_t rdata;
    int    lat;
    int    reqs;
    access(1'b1, addr, data, rdata, lat, reqs);
    shadow[addr[11:2]] = data;
    check_word("core_rdata", rdata, data);
    kind_checks(kind, lat, reqs);
  endtask

  task automatic idle_outputs_low();
    repeat (idle_cycles) begin
      @(posedge clk);
      #1;
      check_flag("core_resp", core_resp, 1'b0);
      check_flag("ddr_req", ddr_req, 1'b0);
    end
  endtask

  task automatic read_miss_then_hits();
    read_and_check(32'h014, miss_kind);
    read_and_check(32'h014, hit_kind);
    read_and_check(32'h018, hit_kind);
  endtask

  task automatic write_hit_merge();
    write_and_check(32'h018, 32'ha5a5_5a5a, hit_kind);
    read_and_check(32'h018, hit_kind);
    read_and_check(32'h010, hit_kind);
    read_and_check(32'h014, hit_kind);
    read_and_check(32'h01c, hit_kind);
  endtask

  // three tags on index 2 with the first one dirty.
  task automatic dirty_eviction();
    word_t writes_before;
    line_t expected;
    write_and_check(32'h020, 32'hc0de_0020, miss_kind);
    writes_before = write_count;
    read_and_check(32'h120, miss_kind);
    read_and_check(32'h220, miss_kind);
    check_word("write_count", write_count - writes_before, 32'd1);
    for (int w = 0; w < words_per_line; w++) begin
      expected[w*word_bits +: word_bits] = shadow[(32'h020 >> 2) + w];
    end
    check_line("last_wdata", last_wdata, expected);
    check_word("last_waddr", last_waddr, 32'h020);
    read_and_check(32'h020, miss_kind);
  endtask

  task automatic replacement_order();
    read_and_check(32'h030, miss_kind);
    read_and_check(32'h130, miss_kind);
    read_and_check(32'h030, hit_kind);
    read_and_check(32'h230, miss_kind); // evicts 0x130, not the recent 0x030.
    read_and_check(32'h030, hit_kind);
    read_and_check(32'h130, miss_kind);
  endtask

  task automatic mixed_sequence();
    word_t r;
    word_t addr;
    for (int n = 0; n < 24; n++) begin
      r    = next_random();
      addr = {20'b0, r[27:24], 3'b010, r[20], r[17:16], 2'b00}; // index 4 or 5.
      if (r[31]) begin
        write_and_check(addr, next_random(), any_kind);
      end else begin
        read_and_check(addr, any_kind);
      end
    end
  endtask

  initial begin
    errors     = 0;
    rst_n      = 1'b0;
    core_req   = 1'b0;
    core_we    = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    rng        = seed;
    fill_key   = next_random(); // one draw keys the whole memory image.
    for (int i = 0; i < shadow_words; i++) begin
      shadow[i] = word_t'(i * 4) ^ fill_key;
    end
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;

    idle_outputs_low();
    read_miss_then_hits();
    write_hit_merge();
    dirty_eviction();
    replacement_order();
    mixed_sequence();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/ddr_model.sv
`default_nettype none

module ddr_model
  import l1cache_pkg::*;
#(
  parameter int num_lines = 256
) (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t fill_key,
  input  logic  ddr_req,
  input  logic  ddr_we,
  input  word_t ddr_addr,
  input  line_t ddr_wdata,
  output logic  ddr_resp,
  output line_t ddr_rdata,
  output word_t write_count,
  output word_t last_waddr,
  output line_t last_wdata
);

  localparam int sel_bits = $clog2(num_lines);

  line_t      mem [num_lines];
  logic [1:0] pending;  // request age so resp leaves on the third edge.
  word_t      addr_q;

  initial begin
    ddr_resp  = 1'b0;
    ddr_rdata = '0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      // every word starts as its own byte address xor the key.
      for (int i = 0; i < num_lines; i++) begin
        for (int w = 0; w < words_per_line; w++) begin
          mem[i][w*word_bits +: word_bits] <= word_t'(i * line_bytes + w * 4) ^ fill_key;
        end
      end
      pending     <= '0;
      addr_q      <= '0;
      ddr_resp    <= 1'b0;
      ddr_rdata   <= '0;
      write_count <= '0;
      last_waddr  <= '0;
      last_wdata  <= '0;
    end else begin
      pending  <= {pending[0], ddr_req};
      ddr_resp <= pending[1];
      if (ddr_req) begin
        addr_q <= ddr_addr;
        if (ddr_we) begin
          mem[ddr_addr[offset_bits +: sel_bits]] <= ddr_wdata;
          write_count <= write_count + 1;
          last_waddr  <= ddr_addr;
          last_wdata  <= ddr_wdata;
        end
      end
      if (pending[1]) begin
        ddr_rdata <= mem[addr_q[offset_bits +: sel_bits]];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/l1cache.sv
`default_nettype none

module l1cache
  import l1cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  // core side.
  input  logic  core_req,
  input  logic  core_we,
  input  word_t core_addr,
  input  word_t core_wdata,
  output logic  core_resp,
  output word_t core_rdata,

  // memory side, one line per transfer.
  output logic  ddr_req,
  output logic  ddr_we,
  output word_t ddr_addr,
  output line_t ddr_wdata,
  input  logic  ddr_resp,
  input  line_t ddr_rdata
);

  word_t req_addr;
  word_t req_wdata;
  logic  write_hit;
  logic  allocate;
  logic  use_victim_addr;
  logic  touch;
  logic  hit;
  logic  victim_dirty;
  logic  victim_valid;

  l1cache_control i_control (
    .clk             (clk),
    .rst_n           (rst_n),
    .core_req        (core_req),
    .core_we         (core_we),
    .core_addr       (core_addr),
    .core_wdata      (core_wdata),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .victim_valid    (victim_valid),
    .ddr_resp        (ddr_resp),
    .req_addr        (req_addr),
    .req_wdata       (req_wdata),
    .write_hit       (write_hit),
    .allocate        (allocate),
    .use_victim_addr (use_victim_addr),
    .touch           (touch),
    .ddr_req         (ddr_req),
    .ddr_we          (ddr_we),
    .core_resp       (core_resp)
  );

  l1cache_datapath i_datapath (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_addr        (req_addr),
    .req_wdata       (req_wdata),
    .write_hit       (write_hit),
    .allocate        (allocate),
    .use_victim_addr (use_victim_addr),
    .touch           (touch),
    .ddr_rdata       (ddr_rdata),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .victim_valid    (victim_valid),
    .rdata           (core_rdata),
    .ddr_addr        (ddr_addr),
    .ddr_wdata       (ddr_wdata)
  );

endmodule

`default_nettype wire

//--- source/l1cache_control.sv
`default_nettype none

module l1cache_control
  import l1cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  input  logic  core_req,
  input  logic  core_we,
  input  word_t core_addr,
  input  word_t core_wdata,

  input  logic  hit,
  input  logic  victim_dirty,
  input  logic  victim_valid,
  input  logic  ddr_resp,

  output word_t req_addr,
  output word_t req_wdata,
  output logic  write_hit,
  output logic  allocate,
  output logic  use_victim_addr,
  output logic  touch,
  output logic  ddr_req,
  output logic  ddr_we,
  output logic  core_resp
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_writeback,
    st_fill,
    st_respond  // lookup again right after the fill.
  } state_t;

  state_t state;
  state_t state_next;
  logic   req_we;
  logic   serve;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // request is captured only when idle, later strobes are dropped.
  always_ff @(posedge clk) begin
    if (state == st_idle && core_req) begin
      req_addr  <= core_addr;
      req_wdata <= core_wdata;
      req_we    <= core_we;
    end
  end

  assign serve     = ((state == st_lookup) || (state == st_respond)) && hit;
  assign core_resp = serve;
  assign write_hit = serve && req_we;
  assign touch     = serve;

  always_comb begin
    state_next      = state;
    ddr_req         = 1'b0;
    ddr_we          = 1'b0;
    use_victim_addr = 1'b0;
    allocate        = 1'b0;

    case (state)
      st_idle: begin
        if (core_req) state_next = st_lookup;
      end
      st_lookup: begin
        if (hit) begin
          state_next = st_idle;
        end else if (victim_valid && victim_dirty) begin
          ddr_req         = 1'b1; // write back the victim first.
          ddr_we          = 1'b1;
          use_victim_addr = 1'b1;
          state_next      = st_writeback;
        end else begin
          ddr_req    = 1'b1;
          state_next = st_fill;
        end
      end
      st_writeback: begin
        if (ddr_resp) begin
          ddr_req    = 1'b1; // fill request follows at once.
          state_next = st_fill;
        end
      end
      st_fill: begin
        if (ddr_resp) begin
          allocate   = 1'b1;
          state_next = st_respond;
        end
      end
      st_respond: begin
        state_next = hit ? st_idle : st_lookup;
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

`default_nettype wire

//--- source/l1cache_datapath.sv
`default_nettype none

module l1cache_datapath
  import l1cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,

  // registered request from control.
  input  word_t req_addr,
  input  word_t req_wdata,

  // one-cycle commands from control.
  input  logic  write_hit,
  input  logic  allocate,
  input  logic  use_victim_addr,
  input  logic  touch,

  input  line_t ddr_rdata,

  output logic  hit,
  output logic  victim_dirty,
  output logic  victim_valid,
  output word_t rdata,
  output word_t ddr_addr,
  output line_t ddr_wdata
);

  tag_t      req_tag;
  index_t    req_index;
  word_sel_t req_word;

  way_vec_t  valid_vec;
  way_vec_t  dirty_vec;
  way_vec_t  hit_vec;
  way_vec_t  victim_vec;
  way_vec_t  load_vec;

  tag_t      tag_out  [num_ways];
  line_t     line_out [num_ways];

  line_t     hit_line;
  line_t     victim_line;
  tag_t      victim_tag;
  line_t     merged_line;
  line_t     fill_line;

  assign req_tag   = req_addr[word_bits-1 -: tag_bits];
  assign req_index = req_addr[offset_bits +: index_bits];
  assign req_word  = req_addr[offset_bits-1 -: word_sel_bits];

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    // a write hit updates its own way, a fill goes to the victim.
    assign load_vec[w] = (write_hit & hit_vec[w]) | (allocate & victim_vec[w]);

    cache_array #(.payload_t(logic)) i_valid (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load_vec[w]),
      .index    (req_index),
      .data_in  (1'b1),
      .data_out (valid_vec[w])
    );

    cache_array #(.payload_t(tag_t)) i_tag (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load_vec[w]),
      .index    (req_index),
      .data_in  (req_tag),
      .data_out (tag_out[w])
    );

    cache_array #(.payload_t(line_t)) i_line (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load_vec[w]),
      .index    (req_index),
      .data_in  (fill_line),
      .data_out (line_out[w])
    );

    cache_array #(.payload_t(logic)) i_dirty (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load_vec[w]),
      .index    (req_index),
      .data_in  (write_hit), // low on allocate.
      .data_out (dirty_vec[w])
    );

    assign hit_vec[w] = valid_vec[w] && (tag_out[w] == req_tag);
  end

  nmru i_nmru (
    .clk     (clk),
    .rst_n   (rst_n),
    .index   (req_index),
    .touch   (touch),
    .hit_way (hit_vec),
    .victim  (victim_vec)
  );

  always_comb begin
    hit_line    = '0;
    victim_line = '0;
    victim_tag  = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit_vec[w]) begin
        hit_line = line_out[w];
      end
      if (victim_vec[w]) begin
        victim_line = line_out[w];
        victim_tag  = tag_out[w];
      end
    end

    hit          = |hit_vec;
    victim_valid = |(valid_vec & victim_vec);
    victim_dirty = |(dirty_vec & victim_vec);

    merged_line = hit_line;
    merged_line[req_word*word_bits +: word_bits] = req_wdata;
    fill_line   = allocate ? ddr_rdata : merged_line;

    // a write answers with the word it stores.
    rdata = write_hit ? req_wdata : hit_line[req_word*word_bits +: word_bits];

    ddr_wdata = victim_line;
    ddr_addr  = {(use_victim_addr ? victim_tag : req_tag), req_index, {offset_bits{1'b0}}};
  end

endmodule

`default_nettype wire

//--- source/nmru.sv
`default_nettype none

module nmru
  import l1cache_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  index_t   index,
  input  logic     touch,
  input  way_vec_t hit_way,
  output way_vec_t victim
);

  way_num_t mru [lines_per_way];
  way_num_t hit_num;
  way_num_t mru_here;

  // one-hot hit vector to way number.
  always_comb begin
    hit_num = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit_way[w]) begin
        hit_num = way_num_t'(w);
      end
    end
  end

  assign mru_here = mru[index];

  // walk downwards so the lowest non-mru way is left standing.
  always_comb begin
    victim = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (way_num_t'(w) != mru_here) begin
        victim    = '0;
        victim[w] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < lines_per_way; i++) begin
        mru[i] <= '0; // way 0 counts as most recent.
      end
    end else if (touch) begin
      mru[index] <= hit_num;
    end
  end

endmodule

`default_nettype wire

//--- source/cache_array.sv
`default_nettype none

module cache_array
  import l1cache_pkg::*;
#(
  parameter type payload_t = logic,
  parameter int  depth     = lines_per_way
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  index_t   index,
  input  payload_t data_in,
  output payload_t data_out
);

  payload_t mem [depth];

  // cleared on reset so every valid bit starts low.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
    end else if (load) begin
      mem[index] <= data_in;
    end
  end

  assign data_out = mem[index]; // combinational read.

endmodule

`default_nettype wire

//--- source/l1cache_pkg.sv
`default_nettype none

`include "l1cache_config.svh"

package l1cache_pkg;

  localparam int num_ways       = `L1_NUM_WAYS;
  localparam int word_bits      = `L1_WORD_BITS;
  localparam int line_bits      = `L1_LINE_BITS;
  localparam int line_bytes     = line_bits / 8;
  localparam int words_per_line = line_bits / word_bits;
  localparam int lines_per_way  = `L1_TOTAL_BYTES / (num_ways * line_bytes);

  // address layout is tag | index | offset.
  localparam int offset_bits    = $clog2(line_bytes);
  localparam int index_bits     = $clog2(lines_per_way);
  localparam int tag_bits       = word_bits - index_bits - offset_bits;
  localparam int word_sel_bits  = $clog2(words_per_line); // upper offset bits.
  localparam int way_bits       = (num_ways > 1) ? $clog2(num_ways) : 1;

  typedef logic [word_bits-1:0]     word_t;
  typedef logic [line_bits-1:0]     line_t;
  typedef logic [index_bits-1:0]    index_t;
  typedef logic [tag_bits-1:0]      tag_t;
  typedef logic [num_ways-1:0]      way_vec_t;  // one-hot over the ways.
  typedef logic [way_bits-1:0]      way_num_t;  // binary way number.
  typedef logic [word_sel_bits-1:0] word_sel_t;

endpackage

`default_nettype wire

//--- include/l1cache_config.svh
`ifndef L1CACHE_CONFIG_SVH
`define L1CACHE_CONFIG_SVH

// capacity in bytes over all ways.
`define L1_TOTAL_BYTES 512

// number of ways which may also be 4.
`define L1_NUM_WAYS 2

// core word width.
`define L1_WORD_BITS 32

// line width of four words.
`define L1_LINE_BITS 128

`endif
